// File: hdl/host_config.svh
// Build-time settings for the host system
// Included by each RTL block that needs a clock ratio, a timing length,
// a port address or a memory size; the testbench reads the same values
`ifndef HOST_CONFIG_SVH
`define HOST_CONFIG_SVH

// Width of the tick counter, one bus tick per 2^N system clocks
`define HOST_CPU_SLOWDOWN 2

// Equal button samples on consecutive ticks before bus reset may change
`define HOST_DEBOUNCE_LEN 4

// System clocks per serial bit
`define HOST_BAUD_DIV 16

// I/O port of the UART transmitter, decoded on the low address byte
`define HOST_UART_PORT 8'h01

// Code memory address width, 10 bits give a 1 KB block
`define HOST_ROM_ABITS 10

`endif

// File: hdl/hostPkg.sv
// Shared types for the host system
// busCycle_t carries everything the bus master puts on the bus,
// testPoints_t gathers the observation signals brought out of the top level

package hostPkg;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus master outputs
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        // Memory address, or I/O port on the low byte
        logic [15:0] addr;
        // Byte driven during an I/O write
        logic [7:0]  wrData;
        // Z80-style strobes, all active low
        logic        nM1;
        logic        nMreq;
        logic        nIorq;
        logic        nRd;
        logic        nWr;
    } busCycle_t;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Observation bundle
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic       busReset;
        logic       tick;
        logic       nM1;
        logic       nMreq;
        logic       nIorq;
        logic       nRd;
        logic       nWr;
        // Low address nibble
        logic [3:0] addrLow;
        // Read data on a read, write data otherwise
        logic [3:0] dataLow;
    } testPoints_t;

endpackage

// File: hdl/clockSlowdown.sv
// Bus tick generator
// A free-running counter on the system clock gives a one-clock tick
// enable once per counter wrap; every slow block advances on that tick
`timescale 1ns/1ps
`include "host_config.svh"

module clockSlowdown (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    // Slowdown counter
    logic [`HOST_CPU_SLOWDOWN-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            // Wraps on its own every 2^N clocks
            count <= count + 1'b1;
            // Registered, so tick follows the zero count by one clock
            tick  <= (count == '0);
        end
    end

endmodule

// File: hdl/resetDebounce.sv
// Push-button reset filter
// The raw button is sampled once per bus tick into a short history;
// the bus reset only follows the button once the history agrees fully,
// so short glitches never reach the bus master or the UART
`timescale 1ns/1ps
`include "host_config.svh"

module resetDebounce (
    input  logic clk,
    input  logic rst,
    input  logic tick,
    input  logic button,
    output logic busReset
);

    localparam int Len = `HOST_DEBOUNCE_LEN;

    // Button samples, newest in bit 0
    logic [Len-1:0] history;
    logic [Len-1:0] historyNext;

    assign historyNext = {history[Len-2:0], button};

    always_ff @(posedge clk) begin
        if (rst) begin
            // Start held in reset until the button is seen released
            history  <= '1;
            busReset <= 1'b1;
        end else if (tick) begin
            history <= historyNext;
            // All pressed sets, all released clears, mixed holds
            if (historyNext == '1) begin
                busReset <= 1'b1;
            end else if (historyNext == '0) begin
                busReset <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/busSequencer.sv
// Simple bus master standing in for a CPU core
// Fetches code bytes from address 0 upward with memory-read cycles and
// sends each one to the UART port with an I/O-write cycle; a zero byte
// ends the program and raises halt until the next bus reset
`timescale 1ns/1ps
`include "host_config.svh"

module busSequencer (
    input  logic               clk,
    input  logic               rst,
    input  logic               tick,
    input  logic               busReset,
    input  logic [7:0]         rdData,
    input  logic               nWait,
    output hostPkg::busCycle_t bus,
    output logic               halt
);

    typedef enum logic [2:0] {
        seqIdle,
        fetchT1,
        fetchT2,
        fetchT3,
        writeT1,
        writeT2,
        writeT3,
        seqHalted
    } seqState_t;

    seqState_t   state;
    // Program counter, next fetch address
    logic [15:0] pc;
    // Byte on its way to the UART
    logic [7:0]  dataReg;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cycle sequencing, one step per tick
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        // Button reset restarts the program just like power-on reset
        if (rst || busReset) begin
            state <= seqIdle;
            pc    <= '0;
            halt  <= 1'b0;
        end else if (tick) begin
            case (state)
                seqIdle: state <= fetchT1;
                fetchT1: state <= fetchT2;
                fetchT2: state <= fetchT3;
                fetchT3: begin
                    // Data sampled at the close of T3
                    if (rdData == 8'h00) begin
                        state <= seqHalted;
                        halt  <= 1'b1;
                    end else begin
                        pc    <= pc + 16'd1;
                        state <= writeT1;
                    end
                end
                writeT1: state <= writeT2;
                // Wait states: T2 repeats while the UART is busy
                writeT2: begin
                    if (nWait) begin
                        state <= writeT3;
                    end
                end
                writeT3: state <= fetchT1;
                default: state <= seqHalted;
            endcase
        end
    end

    // Fetched byte, captured with the same T3 sample
    always_ff @(posedge clk) begin
        if (tick && state == fetchT3) begin
            dataReg <= rdData;
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Strobe and address decode
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        bus.addr   = pc;
        bus.wrData = dataReg;
        bus.nM1    = 1'b1;
        bus.nMreq  = 1'b1;
        bus.nIorq  = 1'b1;
        bus.nRd    = 1'b1;
        bus.nWr    = 1'b1;
        case (state)
            fetchT1, fetchT2, fetchT3: begin
                // Opcode fetch style read
                bus.nM1   = 1'b0;
                bus.nMreq = 1'b0;
                bus.nRd   = 1'b0;
            end
            writeT1, writeT2, writeT3: begin
                // Port number sits on the low address byte
                bus.addr  = {8'h00, `HOST_UART_PORT};
                bus.nIorq = 1'b0;
                bus.nWr   = 1'b0;
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/codeRom.sv
// Read-only code memory in the lowest 1 KB block of the address space
// Contents come from the program image at elaboration; the read is
// registered and only shows on the data lines for a memory read in
// block zero, all other accesses see an idle bus value of FF
`timescale 1ns/1ps
`include "host_config.svh"

module codeRom (
    input  logic               clk,
    input  hostPkg::busCycle_t bus,
    output logic [7:0]         rdData
);

    localparam int ABits = `HOST_ROM_ABITS;
    localparam int Depth = 2 ** ABits;

    // Code storage
    logic [7:0] mem [Depth];
    // Registered read port
    logic [7:0] romQ;
    logic       select;

    initial begin
        $readmemh("hdl/program.hex", mem);
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Block decode
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Upper address bits pick the 1 KB block, only block zero is fitted
    assign select = (bus.addr[15:ABits] == '0) && !bus.nMreq && !bus.nRd;

    // Synchronous read, address is stable from T1 so data is ready by T3
    always_ff @(posedge clk) begin
        romQ <= mem[bus.addr[ABits-1:0]];
    end

    // Undriven bus reads as all ones
    assign rdData = select ? romQ : 8'hFF;

endmodule

// File: hdl/uartTx.sv
// Byte-wide serial transmitter on the I/O space
// An I/O write to the UART port loads one frame: start bit, eight data
// bits LSB first, stop bit. nWait holds the bus master in T2 while the
// port is addressed and a frame is still going out
`timescale 1ns/1ps
`include "host_config.svh"

module uartTx (
    input  logic               clk,
    input  logic               rst,
    input  logic               busReset,
    input  hostPkg::busCycle_t bus,
    output logic               nWait,
    output logic               txd
);

    localparam int DivBits = $clog2(`HOST_BAUD_DIV);

    logic               select;
    logic               busy;
    // Set once this write cycle's byte is taken
    logic               loaded;
    logic               load;
    // Frame bits, next bit out in bit 0
    logic [9:0]         shiftReg;
    logic [DivBits-1:0] baudCnt;
    logic [3:0]         bitCnt;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Port decode and bus handshake
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Z80 ports decode on the low address byte only
    assign select = !bus.nIorq && !bus.nWr && (bus.addr[7:0] == `HOST_UART_PORT);
    // One load per write cycle, and only when idle
    assign load   = select && !loaded && !busy;
    assign nWait  = !(select && busy);

    always_ff @(posedge clk) begin
        if (rst || busReset) begin
            busy    <= 1'b0;
            loaded  <= 1'b0;
            baudCnt <= '0;
            bitCnt  <= '0;
        end else begin
            // Re-arm when the write strobes go away
            if (!select) begin
                loaded <= 1'b0;
            end else if (load) begin
                loaded <= 1'b1;
            end

            if (load) begin
                busy    <= 1'b1;
                baudCnt <= '0;
                bitCnt  <= '0;
            end else if (busy) begin
                if (baudCnt == DivBits'(`HOST_BAUD_DIV - 1)) begin
                    baudCnt <= '0;
                    // Last bit period is the stop bit
                    if (bitCnt == 4'd9) begin
                        busy <= 1'b0;
                    end else begin
                        bitCnt <= bitCnt + 4'd1;
                    end
                end else begin
                    baudCnt <= baudCnt + 1'b1;
                end
            end
        end
    end

    // Frame shifter
    always_ff @(posedge clk) begin
        if (load) begin
            shiftReg <= {1'b1, bus.wrData, 1'b0};
        end else if (busy && baudCnt == DivBits'(`HOST_BAUD_DIV - 1)) begin
            shiftReg <= {1'b1, shiftReg[9:1]};
        end
    end

    // Line idles high between frames
    assign txd = busy ? shiftReg[0] : 1'b1;

endmodule

// File: hdl/hostTop.sv
// Top level of the host system
// Ties the tick generator, reset filter, bus master, code memory and
// UART together; drives the serial line, halt and the test points
`timescale 1ns/1ps

module hostTop (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 button,
    output logic                 txd,
    output logic                 halt,
    output hostPkg::testPoints_t testPoints
);

    import hostPkg::*;

    logic       tick;
    logic       busReset;
    busCycle_t  bus;
    logic [7:0] rdData;
    logic       nWait;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Clocking and reset
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    clockSlowdown clockSlowdown_inst (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    resetDebounce resetDebounce_inst (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .button   (button),
        .busReset (busReset)
    );

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus master and peripherals
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    busSequencer busSequencer_inst (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .busReset (busReset),
        .rdData   (rdData),
        .nWait    (nWait),
        .bus      (bus),
        .halt     (halt)
    );

    codeRom codeRom_inst (
        .clk    (clk),
        .bus    (bus),
        .rdData (rdData)
    );

    uartTx uartTx_inst (
        .clk      (clk),
        .rst      (rst),
        .busReset (busReset),
        .bus      (bus),
        .nWait    (nWait),
        .txd      (txd)
    );

    // Test points
    always_comb begin
        testPoints.busReset = busReset;
        testPoints.tick     = tick;
        testPoints.nM1      = bus.nM1;
        testPoints.nMreq    = bus.nMreq;
        testPoints.nIorq    = bus.nIorq;
        testPoints.nRd      = bus.nRd;
        testPoints.nWr      = bus.nWr;
        testPoints.addrLow  = bus.addr[3:0];
        // Show whichever side is driving the data lines
        testPoints.dataLow  = !bus.nRd ? rdData[3:0] : bus.wrData[3:0];
    end

endmodule

// File: verification/hostTb.sv
// Testbench for the host system
// Holds and releases the reset button, makes a short glitch and a long
// press, decodes the serial line and checks the frames against the
// program image, plus the bus strobes, fetch addresses and halt
`timescale 1ns/1ps
`include "host_config.svh"

module hostTb;

    import hostPkg::*;

    localparam int BaudDiv    = `HOST_BAUD_DIV;
    localparam int DebLen     = `HOST_DEBOUNCE_LEN;
    localparam int TickClocks = 1 << `HOST_CPU_SLOWDOWN;
    localparam int ABits      = `HOST_ROM_ABITS;
    localparam int Depth      = 1 << `HOST_ROM_ABITS;

    logic        clk = 1'b0;
    logic        rst;
    logic        button;
    logic        txd;
    logic        halt;
    testPoints_t testPoints;
    logic [4:0]  strobes;

    // Expected bytes, everything before the first zero
    logic [7:0]  image [Depth];
    logic [7:0]  progBytes [$];
    int          progLen;
    int          cycleLimit;
    int          cycles = 0;
    int          seed = 32'h66d7_9d6e;

    // One error counter per checking process
    int          mainErrors = 0;
    int          rxErrors = 0;
    int          busErrors = 0;
    int          strobeErrors = 0;
    int          txdErrors = 0;
    int          overlapErrors = 0;
    int          tickErrors = 0;

    // Serial decoder state
    logic        rxActive = 1'b0;
    logic        rxLevel;
    logic        txdPrev = 1'b1;
    logic [9:0]  rxShift;
    int          rxCount;
    int          rxIndex = 0;
    int          pos;
    int          framesDone = 0;

    // Bus monitor state
    logic        nM1Prev = 1'b1;
    logic        nWrPrev = 1'b1;
    logic        haltPrev = 1'b0;
    logic        busResetPrev = 1'b0;
    logic [7:0]  wrExpected;
    int          fetchAddr = 0;
    int          resetRises = 0;

    // Clocks since the last bus tick, zero until the first one
    int          tickGap = 0;

    always #20 clk = ~clk;

    hostTop hostTop_inst (
        .clk        (clk),
        .rst        (rst),
        .button     (button),
        .txd        (txd),
        .halt       (halt),
        .testPoints (testPoints)
    );

    assign strobes = {testPoints.nM1, testPoints.nMreq, testPoints.nIorq,
                      testPoints.nRd, testPoints.nWr};

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus invariants
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus reset seen on two samples, so the bus master has taken it
    strobesIdle: assert property (@(posedge clk) disable iff (rst)
        (testPoints.busReset && $past(testPoints.busReset)) |-> (strobes == 5'b11111))
        else begin
            strobeErrors++;
            $display("FAIL %0t: strobes expected 11111 got %b", $time, $sampled(strobes));
        end

    txdIdle: assert property (@(posedge clk) disable iff (rst)
        (testPoints.busReset && $past(testPoints.busReset)) |-> txd)
        else begin
            txdErrors++;
            $display("FAIL %0t: txd expected 1 got %b", $time, $sampled(txd));
        end

    // Read and write strobes never overlap
    rdWrExclusive: assert property (@(posedge clk) disable iff (rst)
        !(!testPoints.nRd && !testPoints.nWr))
        else begin
            overlapErrors++;
            $display("Read and write strobes both active at %0t", $time);
        end

    // Tick period
    always @(posedge clk) begin
        if (rst) begin
            tickGap = 0;
        end else if (testPoints.tick) begin
            // First tick after reset has no period before it
            if (tickGap != 0) begin
                assert (tickGap == TickClocks) else begin
                    tickErrors++;
                    $display("FAIL %0t: tick period expected %0d got %0d", $time,
                             TickClocks, tickGap);
                end
            end
            tickGap = 1;
        end else if (tickGap != 0) begin
            tickGap++;
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial decoder, one sample per clock
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (rst || testPoints.busReset) begin
            // Replay starts again from the first byte
            rxActive = 1'b0;
            rxIndex  = 0;
        end else begin
            // Falling edge on an idle line opens a frame
            if (!rxActive && txdPrev && !txd) begin
                assert (!halt) else begin
                    rxErrors++;
                    $display("A frame started after halt at %0t", $time);
                end
                rxActive = 1'b1;
                rxCount  = 0;
            end
            if (rxActive) begin
                pos = rxCount % BaudDiv;
                // Level of each bit must hold for the whole bit period
                if (pos == 0) begin
                    rxLevel = txd;
                end else begin
                    assert (txd == rxLevel) else begin
                        rxErrors++;
                        $display("FAIL %0t: txd expected %b got %b", $time, rxLevel, txd);
                    end
                end
                // Mid-bit sample, LSB arrives first
                if (pos == BaudDiv / 2) begin
                    rxShift = {txd, rxShift[9:1]};
                end
                rxCount++;
                if (rxCount == 10 * BaudDiv) begin
                    rxActive = 1'b0;
                    assert (!rxShift[0]) else begin
                        rxErrors++;
                        $display("FAIL %0t: start bit expected 0 got 1", $time);
                    end
                    assert (rxShift[9]) else begin
                        rxErrors++;
                        $display("FAIL %0t: stop bit expected 1 got 0", $time);
                    end
                    if (rxIndex >= progLen) begin
                        rxErrors++;
                        $display("Extra frame %02h received at %0t", rxShift[8:1], $time);
                    end else begin
                        assert (rxShift[8:1] == progBytes[rxIndex]) else begin
                            rxErrors++;
                            $display("FAIL %0t: frame[%0d] expected %02h got %02h", $time,
                                     rxIndex, progBytes[rxIndex], rxShift[8:1]);
                        end
                    end
                    rxIndex++;
                end
            end
        end
        txdPrev = txd;
        framesDone <= rxIndex;
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch addresses, write data and halt
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (rst || testPoints.busReset) begin
            fetchAddr = 0;
        end else begin
            // Start of a memory read, nM1 just fell
            if (nM1Prev && !testPoints.nM1) begin
                assert (testPoints.addrLow == fetchAddr[3:0]) else begin
                    busErrors++;
                    $display("FAIL %0t: addrLow expected %h got %h", $time,
                             fetchAddr[3:0], testPoints.addrLow);
                end
                fetchAddr++;
            end
            // Start of an I/O write, carries the byte just fetched
            if (nWrPrev && !testPoints.nWr && fetchAddr >= 1 && fetchAddr <= progLen) begin
                wrExpected = progBytes[fetchAddr - 1];
                assert (testPoints.dataLow == wrExpected[3:0]) else begin
                    busErrors++;
                    $display("FAIL %0t: dataLow expected %h got %h", $time,
                             wrExpected[3:0], testPoints.dataLow);
                end
            end
            // Halt only once the zero byte has been fetched
            if (!haltPrev && halt) begin
                assert (fetchAddr == progLen + 1) else begin
                    busErrors++;
                    $display("FAIL %0t: fetch count at halt expected %0d got %0d", $time,
                             progLen + 1, fetchAddr);
                end
            end
        end
        if (!busResetPrev && testPoints.busReset) begin
            resetRises <= resetRises + 1;
        end
        nM1Prev      = testPoints.nM1;
        nWrPrev      = testPoints.nWr;
        haltPrev     = halt;
        busResetPrev = testPoints.busReset;
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TB FAILED");
            $finish;
        end
    end

    // Counts bus ticks as seen at the rising edge
    task automatic waitTicks(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk);
            if (testPoints.tick) begin
                seen++;
            end
        end
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int idx;
        int glitchTicks;
        int risesBefore;
        int totalErrors;

        rst    <= 1'b1;
        button <= 1'b1;
        $readmemh("hdl/program.hex", image);
        idx = 0;
        while (idx < Depth && image[ABits'(idx)] != 8'h00) begin
            progBytes.push_back(image[ABits'(idx)]);
            idx++;
        end
        progLen = progBytes.size();
        // Two program runs, plus the button phases
        cycleLimit = 3 * (progLen + 1) * (10 * BaudDiv + 6 * TickClocks)
                     + 16 * DebLen * TickClocks + 3;

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Button still pressed, bus stays in reset
        waitTicks(2 * DebLen);
        assert (testPoints.busReset) else begin
            mainErrors++;
            $display("FAIL %0t: busReset expected 1 got 0", $time);
        end
        button <= 1'b0;
        while (testPoints.busReset) @(posedge clk);

        // Short glitch in the middle of the transmission
        while (framesDone < 2) @(posedge clk);
        glitchTicks = 1 + int'({$random(seed)} % (DebLen - 1));
        risesBefore = resetRises;
        waitTicks(1);
        button <= 1'b1;
        waitTicks(glitchTicks);
        button <= 1'b0;
        waitTicks(DebLen + 1);
        assert (!testPoints.busReset && resetRises == risesBefore) else begin
            mainErrors++;
            $display("FAIL %0t: busReset expected 0 got %b, rises expected %0d got %0d",
                     $time, testPoints.busReset, risesBefore, resetRises);
        end

        // First run to the zero byte
        while (!halt) @(posedge clk);
        waitTicks(4);
        assert (framesDone == progLen) else begin
            mainErrors++;
            $display("FAIL %0t: frames expected %0d got %0d", $time, progLen, framesDone);
        end

        // Long press restarts the program
        button <= 1'b1;
        while (!testPoints.busReset) @(posedge clk);
        repeat (2) @(posedge clk);
        assert (!halt) else begin
            mainErrors++;
            $display("FAIL %0t: halt expected 0 got 1", $time);
        end
        waitTicks(2);
        button <= 1'b0;
        while (testPoints.busReset) @(posedge clk);
        while (!halt) @(posedge clk);
        waitTicks(4);
        assert (framesDone == progLen) else begin
            mainErrors++;
            $display("FAIL %0t: replayed frames expected %0d got %0d", $time,
                     progLen, framesDone);
        end

        totalErrors = mainErrors + rxErrors + busErrors + strobeErrors + txdErrors
                      + overlapErrors + tickErrors;
        $display("Run complete: %0d errors (sequence %0d, serial %0d, fetch %0d, bus %0d)",
                 totalErrors, mainErrors, rxErrors, busErrors,
                 strobeErrors + txdErrors + overlapErrors + tickErrors);
        if (totalErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hdl
hdl/hostPkg.sv
hdl/clockSlowdown.sv
hdl/resetDebounce.sv
hdl/busSequencer.sv
hdl/codeRom.sv
hdl/uartTx.sv
hdl/hostTop.sv
verification/hostTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the host system testbench with Verilator and runs it.
# The result is decided by the messages in the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --assert --timing -f verilog.f --top-module hostTb -Mdir "$BUILD" -o hostSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD/hostSim" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
    echo "No pass message found in $LOG"
    exit 1
fi
exit 0

// File: hdl/program.hex
// One code byte per line in hex, loaded from address 0 upward
// The first 00 byte ends the program
48
6F
73
74
0D
0A
A5
5A
01
80
FE
00
